//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := iq_tb
FLIST     := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+.
iq_pkg.sv
iq_dispatch.sv
issue_queue.sv
iq_regread.sv
iq_top.sv
iq_tb.sv

//--- iq_consts.svh
`ifndef IQ_CONSTS_SVH
`define IQ_CONSTS_SVH

// queue geometry
`define IQ_DEPTH 8
`define IQ_PORTS 2

// sources per instruction
`define IQ_NUM_SRCS 2

// physical register file
`define IQ_PREG_W 6
`define IQ_DATA_W 32

// instruction identity for checking
`define IQ_TAG_W 6

// result buses into the issue stage
`define IQ_WB_PORTS 2

`endif

//--- iq_dispatch.sv
`include "iq_consts.svh"

module iq_dispatch
    import iq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic [`IQ_PORTS-1:0] i_in_vld,
    input  exe_info_t [`IQ_PORTS-1:0] i_in_info,
    output logic o_in_ready,
    input  logic i_can_enq,
    input  logic [(1<<`IQ_PREG_W)-1:0] i_preg_valid,
    input  wb_port_t [`IQ_WB_PORTS-1:0] i_wb,
    output logic [`IQ_PORTS-1:0] o_enq_req,
    output exe_info_t [`IQ_PORTS-1:0] o_enq_info,
    output logic [`IQ_PORTS-1:0][`IQ_NUM_SRCS-1:0] o_enq_src_rdy,
    output logic [`IQ_PORTS-1:0] o_dst_busy_vld,
    output preg_idx_t [`IQ_PORTS-1:0] o_dst_busy_idx
);

    localparam int PORTS = `IQ_PORTS;
    localparam int NSRC = `IQ_NUM_SRCS;

    logic [PORTS-1:0] stage_vld;
    exe_info_t [PORTS-1:0] stage_info;
    logic [PORTS-1:0][NSRC-1:0] stage_rdy;
    logic [PORTS-1:0][NSRC-1:0] in_rdy;

    function automatic logic wb_hit(preg_idx_t idx, wb_port_t [`IQ_WB_PORTS-1:0] wb);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < `IQ_WB_PORTS; w++) begin
            hit |= wb[w].vld && (wb[w].idx == idx);
        end
        return hit;
    endfunction

    // staging must be empty and the queue must have room for a pair
    assign o_in_ready = ~|stage_vld & i_can_enq;

    // initial readiness of arriving sources
    always_comb begin
        for (int p = 0; p < PORTS; p++) begin
            for (int s = 0; s < NSRC; s++) begin
                in_rdy[p][s] = i_preg_valid[i_in_info[p].src_idx[s]] ||
                               wb_hit(i_in_info[p].src_idx[s], i_wb);
                // a younger slot cannot read what the older slot of its pair produces
                for (int q = 0; q < p; q++) begin
                    if (i_in_vld[q] && i_in_info[q].dst_wen &&
                        i_in_info[q].dst_idx == i_in_info[p].src_idx[s]) begin
                        in_rdy[p][s] = 1'b0;
                    end
                end
            end
        end
    end

    // writebacks in the move cycle still count
    always_comb begin
        for (int p = 0; p < PORTS; p++) begin
            for (int s = 0; s < NSRC; s++) begin
                o_enq_src_rdy[p][s] = stage_rdy[p][s] || wb_hit(stage_info[p].src_idx[s], i_wb);
            end
            o_dst_busy_vld[p] = stage_vld[p] & i_can_enq & stage_info[p].dst_wen;
            o_dst_busy_idx[p] = stage_info[p].dst_idx;
        end
    end

    assign o_enq_req = stage_vld;
    assign o_enq_info = stage_info;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_vld <= '0;
        end else if (o_in_ready) begin
            stage_vld <= i_in_vld;
        end else if (i_can_enq) begin
            // pair moves into the queue
            stage_vld <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (o_in_ready) begin
            stage_info <= i_in_info;
            stage_rdy <= in_rdy;
        end else begin
            stage_rdy <= o_enq_src_rdy;
        end
    end

    a_in_when_ready: assert property (@(posedge clk) disable iff (rst)
        |i_in_vld |-> o_in_ready);

endmodule

//--- iq_input.txt
# P preg value_hex : preload through a writeback port
# I tag src0 src1 dst wen value_hex, twice : one instruction pair, older first
# H start_count length : hold issue once start_count instructions were sent
P 1 11110001
P 2 22220002
P 3 33330003
P 4 44440004
P 5 55550005
P 6 66660006
P 7 77770007
P 8 88880008
#
# first pair reads preloads only
I 1 1 2 20 1 a0000014 2 3 4 21 1 a1000015
# younger slot reads the older slot's destination
I 3 20 21 22 1 a2000016 4 22 5 23 1 a3000017
I 5 6 7 24 1 a4000018 6 23 24 25 1 a5000019
I 7 25 1 26 1 a600001a 8 2 26 27 1 a700001b
# no destination write, zero sources
I 9 0 0 28 0 00000000 10 27 8 29 1 a900001d
I 11 29 29 30 1 aa00001e 12 30 3 31 1 ab00001f
I 13 4 5 32 1 ac000020 14 6 7 33 1 ad000021
I 15 32 33 34 1 ae000022 16 31 34 35 1 af000023
I 17 35 1 36 1 b0000024 18 9 10 37 0 00000000
I 19 36 37 38 1 b2000026 20 28 30 39 1 b3000027
I 21 38 39 40 1 b4000028 22 40 36 41 1 b5000029
I 23 41 2 42 1 b600002a 24 20 41 43 1 b700002b
#
# long window fills the queue, short one late in the stream
H 4 16
H 18 5

//--- iq_pkg.sv
`include "iq_consts.svh"

package iq_pkg;

    typedef logic [`IQ_PREG_W-1:0] preg_idx_t;
    typedef logic [$clog2(`IQ_DEPTH)-1:0] iq_idx_t;
    typedef logic [`IQ_DATA_W-1:0] reg_data_t;
    typedef logic [`IQ_TAG_W-1:0] inst_tag_t;

    // what the execution side needs from a renamed instruction
    typedef struct packed {
        inst_tag_t tag;
        preg_idx_t [`IQ_NUM_SRCS-1:0] src_idx;
        preg_idx_t dst_idx;
        logic dst_wen;
    } exe_info_t;

    typedef struct packed {
        exe_info_t info;
        reg_data_t [`IQ_NUM_SRCS-1:0] src_data;
    } issue_bundle_t;

    typedef struct packed {
        logic vld;
        preg_idx_t idx;
        reg_data_t data;
    } wb_port_t;

    // spec_rdy is always a superset of src_rdy
    typedef struct packed {
        logic vld;
        logic issued;
        logic [`IQ_NUM_SRCS-1:0] src_rdy;
        logic [`IQ_NUM_SRCS-1:0] src_spec_rdy;
        exe_info_t info;
    } iq_entry_t;

endpackage

//--- iq_regread.sv
`include "iq_consts.svh"

module iq_regread
    import iq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic [`IQ_PORTS-1:0] i_can_issue,
    input  iq_idx_t [`IQ_PORTS-1:0] i_issue_idx,
    input  exe_info_t [`IQ_PORTS-1:0] i_issue_info,
    input  logic i_issue_hold,
    input  wb_port_t [`IQ_WB_PORTS-1:0] i_wb,
    input  logic [`IQ_PORTS-1:0] i_dst_busy_vld,
    input  preg_idx_t [`IQ_PORTS-1:0] i_dst_busy_idx,
    output logic [(1<<`IQ_PREG_W)-1:0] o_preg_valid,
    output logic [`IQ_PORTS-1:0] o_finished,
    output logic [`IQ_PORTS-1:0] o_replay,
    output iq_idx_t [`IQ_PORTS-1:0] o_feedback_idx,
    output logic [`IQ_PORTS-1:0] o_out_vld,
    output issue_bundle_t [`IQ_PORTS-1:0] o_out_bundle
);

    localparam int NUM_PREGS = 1 << `IQ_PREG_W;
    localparam int PORTS = `IQ_PORTS;
    localparam int NSRC = `IQ_NUM_SRCS;

    reg_data_t preg_data [NUM_PREGS];
    logic [NUM_PREGS-1:0] preg_valid;

    assign o_preg_valid = preg_valid;
    assign o_feedback_idx = i_issue_idx;

    // finish needs every operand present and no hold
    always_comb begin
        logic srcs_ok;
        for (int p = 0; p < PORTS; p++) begin
            srcs_ok = 1'b1;
            for (int s = 0; s < NSRC; s++) begin
                srcs_ok &= preg_valid[i_issue_info[p].src_idx[s]];
            end
            o_finished[p] = i_can_issue[p] && !i_issue_hold && srcs_ok;
            o_replay[p] = i_can_issue[p] && !o_finished[p];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // everything reads as zero until first written
            preg_valid <= '1;
            for (int r = 0; r < NUM_PREGS; r++) begin
                preg_data[r] <= '0;
            end
        end else begin
            for (int p = 0; p < PORTS; p++) begin
                if (i_dst_busy_vld[p]) begin
                    preg_valid[i_dst_busy_idx[p]] <= 1'b0;
                end
            end
            for (int w = 0; w < `IQ_WB_PORTS; w++) begin
                if (i_wb[w].vld) begin
                    preg_valid[i_wb[w].idx] <= 1'b1;
                    preg_data[i_wb[w].idx] <= i_wb[w].data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_out_vld <= '0;
        end else begin
            o_out_vld <= o_finished;
        end
    end

    // operand capture, T2 result
    always_ff @(posedge clk) begin
        for (int p = 0; p < PORTS; p++) begin
            if (o_finished[p]) begin
                o_out_bundle[p].info <= i_issue_info[p];
                for (int s = 0; s < NSRC; s++) begin
                    o_out_bundle[p].src_data[s] <= preg_data[i_issue_info[p].src_idx[s]];
                end
            end
        end
    end

    // sources read for a result stay valid until it has left
    for (genvar p = 0; p < PORTS; p++) begin : g_chk
        a_out_srcs_valid: assert property (@(posedge clk) disable iff (rst)
            o_out_vld[p] |-> preg_valid[o_out_bundle[p].info.src_idx[0]] &&
                             preg_valid[o_out_bundle[p].info.src_idx[1]]);
    end

endmodule

//--- iq_tb.sv
`include "iq_consts.svh"

module iq_tb
    import iq_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_PREGS = 1 << `IQ_PREG_W;
    localparam int NUM_TAGS = 1 << `IQ_TAG_W;
    localparam int IDLE_LIMIT = 100;
    localparam int CYCLE_LIMIT = 5000;

    logic clk = 1'b0;
    logic rst;
    logic [`IQ_PORTS-1:0] in_vld;
    exe_info_t [`IQ_PORTS-1:0] in_info;
    logic in_ready;
    wb_port_t [`IQ_WB_PORTS-1:0] wb;
    logic issue_hold;
    logic [`IQ_PORTS-1:0] spec_vld;
    preg_idx_t [`IQ_PORTS-1:0] spec_idx;
    logic [`IQ_PORTS-1:0] out_vld;
    issue_bundle_t [`IQ_PORTS-1:0] out_bundle;

    integer seed = 40280;
    int value_errs = 0;
    int count_errs = 0;
    int other_errs = 0;

    // contents of the data file
    exe_info_t [`IQ_PORTS-1:0] pairs[$];
    int hold_start[$];
    int hold_len[$];
    preg_idx_t pre_idx[$];
    reg_data_t pre_data[$];
    exe_info_t info_of[NUM_TAGS];
    bit known[NUM_TAGS];
    reg_data_t result_of[NUM_PREGS];
    bit is_dest[NUM_PREGS];

    // reference register file and pending writebacks
    reg_data_t ref_data[NUM_PREGS];
    bit ref_written[NUM_PREGS];
    bit wb_sched[NUM_PREGS];
    preg_idx_t wbq_idx[$];
    reg_data_t wbq_data[$];
    int wbq_due[$];

    int seen[NUM_TAGS];
    int accept_cyc[NUM_TAGS];
    bit lat_check[NUM_TAGS];
    int cyc = 0;
    int idle = 0;
    int ptr = 0;
    int sent = 0;
    int outstanding = 0;
    int hold_ptr = 0;
    int hold_left = 0;
    int last_hold_cyc = -1;
    int low_run = 0;
    int max_low = 0;
    bit preloaded = 1'b0;
    bit timing = 1'b0;
    bit stop = 1'b0;
    logic ready_now;

    always #5 clk = ~clk;

    iq_top u_dut (
        .clk(clk),
        .rst(rst),
        .i_in_vld(in_vld),
        .i_in_info(in_info),
        .o_in_ready(in_ready),
        .i_wb(wb),
        .i_issue_hold(issue_hold),
        .o_spec_wakeup_vld(spec_vld),
        .o_spec_wakeup_idx(spec_idx),
        .o_out_vld(out_vld),
        .o_out_bundle(out_bundle)
    );

    function automatic exe_info_t make_info(int tag, int src0, int src1, int dst, int wen);
        exe_info_t info;
        info.tag = inst_tag_t'(tag);
        info.src_idx[0] = preg_idx_t'(src0);
        info.src_idx[1] = preg_idx_t'(src1);
        info.dst_idx = preg_idx_t'(dst);
        info.dst_wen = (wen != 0);
        return info;
    endfunction

    // sources that no instruction in the file produces
    function automatic bit is_independent(exe_info_t [`IQ_PORTS-1:0] pr);
        bit ok;
        ok = 1'b1;
        for (int q = 0; q < `IQ_PORTS; q++) begin
            for (int s = 0; s < `IQ_NUM_SRCS; s++) begin
                if (is_dest[pr[q].src_idx[s]]) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    task automatic add_inst(exe_info_t info, reg_data_t value);
        info_of[info.tag] = info;
        known[info.tag] = 1'b1;
        if (info.dst_wen) begin
            is_dest[info.dst_idx] = 1'b1;
            result_of[info.dst_idx] = value;
            ref_written[info.dst_idx] = 1'b0;
        end
    endtask

    task automatic load_input();
        int fd;
        int n;
        string line;
        int t0, a0, b0, d0, w0, t1, a1, b1, d1, w1;
        reg_data_t v0;
        reg_data_t v1;
        exe_info_t [`IQ_PORTS-1:0] pr;
        fd = $fopen("iq_input.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("ERROR: cannot open iq_input.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] == "P") begin
                n = $sscanf(line, "P %d %h", a0, v0);
                pre_idx.push_back(preg_idx_t'(a0));
                pre_data.push_back(v0);
            end else if (n > 0 && line.len() > 1 && line[0] == "H") begin
                n = $sscanf(line, "H %d %d", a0, b0);
                hold_start.push_back(a0);
                hold_len.push_back(b0);
            end else if (n > 0 && line.len() > 1 && line[0] == "I") begin
                n = $sscanf(line, "I %d %d %d %d %d %h %d %d %d %d %d %h",
                            t0, a0, b0, d0, w0, v0, t1, a1, b1, d1, w1, v1);
                if (n != 12) begin
                    other_errs++;
                    $display("ERROR: malformed instruction line: %s", line);
                end
                pr[0] = make_info(t0, a0, b0, d0, w0);
                pr[1] = make_info(t1, a1, b1, d1, w1);
                add_inst(pr[0], v0);
                add_inst(pr[1], v1);
                pairs.push_back(pr);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_bundle(issue_bundle_t got, issue_bundle_t want);
        if (got !== want) begin
            value_errs++;
            $display("FAIL t=%0t tag %0d: bundle %h, expected %h",
                     $time, want.info.tag, got, want);
        end
    endtask

    task automatic check_count(string what, inst_tag_t got, inst_tag_t want);
        if (got !== want) begin
            count_errs++;
            $display("FAIL t=%0t %s: got %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic queue_writeback(preg_idx_t idx, reg_data_t data, int due);
        wbq_idx.push_back(idx);
        wbq_data.push_back(data);
        wbq_due.push_back(due);
    endtask

    task automatic check_outputs();
        issue_bundle_t want;
        inst_tag_t tag;
        for (int p = 0; p < `IQ_PORTS; p++) begin
            if (out_vld[p]) begin
                tag = out_bundle[p].info.tag;
                outstanding--;
                idle = 0;
                if (issue_hold) begin
                    value_errs++;
                    $display("FAIL t=%0t tag %0d left during a hold window", $time, tag);
                end
                if (!known[tag]) begin
                    value_errs++;
                    $display("FAIL t=%0t unknown tag %0d on port %0d", $time, tag, p);
                end else begin
                    seen[tag]++;
                    want.info = info_of[tag];
                    for (int s = 0; s < `IQ_NUM_SRCS; s++) begin
                        want.src_data[s] = ref_data[want.info.src_idx[s]];
                        if (!ref_written[want.info.src_idx[s]]) begin
                            value_errs++;
                            $display("FAIL t=%0t tag %0d left before p%0d was written back",
                                     $time, tag, want.info.src_idx[s]);
                        end
                    end
                    check_bundle(out_bundle[p], want);
                    if (lat_check[tag] && last_hold_cyc < accept_cyc[tag]) begin
                        check_count("latency of independent tag",
                                    inst_tag_t'(cyc - accept_cyc[tag]), inst_tag_t'(3));
                    end
                end
            end
        end
    endtask

    // writeback of a selected producer after 0 to 3 cycles
    task automatic schedule_wakeups();
        preg_idx_t idx;
        for (int p = 0; p < `IQ_PORTS; p++) begin
            idx = spec_idx[p];
            if (spec_vld[p] && !is_dest[idx]) begin
                value_errs++;
                $display("FAIL t=%0t wakeup on port %0d names p%0d, which nothing writes",
                         $time, p, idx);
            end
            if (spec_vld[p] && is_dest[idx] && !wb_sched[idx]) begin
                wb_sched[idx] = 1'b1;
                queue_writeback(idx, result_of[idx], cyc + int'($unsigned($random(seed)) % 4));
            end
        end
    endtask

    task automatic drive_writebacks();
        int i;
        int k;
        i = 0;
        k = 0;
        wb = '0;
        while (i < wbq_idx.size() && k < `IQ_WB_PORTS) begin
            if (wbq_due[i] <= cyc) begin
                wb[k].vld = 1'b1;
                wb[k].idx = wbq_idx[i];
                wb[k].data = wbq_data[i];
                ref_data[wbq_idx[i]] = wbq_data[i];
                ref_written[wbq_idx[i]] = 1'b1;
                wbq_idx.delete(i);
                wbq_data.delete(i);
                wbq_due.delete(i);
                k++;
            end else begin
                i++;
            end
        end
    endtask

    task automatic drive_stimulus();
        bit indep;
        inst_tag_t tag;
        // an independent pair runs alone so that its latency is its own
        if (ptr < pairs.size() && preloaded && ready_now &&
            !(timing && outstanding > 0)) begin
            indep = (outstanding == 0) && is_independent(pairs[ptr]);
            timing = indep;
            in_vld = '1;
            in_info = pairs[ptr];
            for (int q = 0; q < `IQ_PORTS; q++) begin
                tag = pairs[ptr][q].tag;
                // staged at the next edge
                accept_cyc[tag] = cyc + 1;
                lat_check[tag] = indep;
            end
            outstanding += `IQ_PORTS;
            sent += `IQ_PORTS;
            ptr++;
            idle = 0;
            low_run = 0;
        end else begin
            in_vld = '0;
            if (ptr < pairs.size() && preloaded && !ready_now) begin
                low_run++;
                if (low_run > max_low) begin
                    max_low = low_run;
                end
            end
        end
    endtask

    task automatic drive_hold();
        if (hold_left > 0) begin
            issue_hold = 1'b1;
            hold_left--;
        end else if (hold_ptr < hold_start.size() && sent >= hold_start[hold_ptr]) begin
            issue_hold = 1'b1;
            hold_left = hold_len[hold_ptr] - 1;
            hold_ptr++;
        end else begin
            issue_hold = 1'b0;
        end
        if (issue_hold) begin
            last_hold_cyc = cyc;
        end
    endtask

    initial begin
        rst = 1'b1;
        in_vld = '0;
        in_info = '0;
        wb = '0;
        issue_hold = 1'b0;
        for (int r = 0; r < NUM_PREGS; r++) begin
            ref_data[r] = '0;
            ref_written[r] = 1'b1;
        end
        load_input();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < pre_idx.size(); i++) begin
            queue_writeback(pre_idx[i], pre_data[i], 0);
        end

        while (!stop) begin
            @(negedge clk);
            cyc++;
            idle++;
            ready_now = in_ready;
            check_outputs();
            schedule_wakeups();
            if (wbq_idx.size() == 0) begin
                preloaded = 1'b1;
            end
            drive_writebacks();
            drive_stimulus();
            drive_hold();
            if (ptr == pairs.size() && outstanding == 0 && wbq_idx.size() == 0) begin
                stop = 1'b1;
            end else if (idle > IDLE_LIMIT) begin
                other_errs++;
                if (ptr < pairs.size()) begin
                    $display("ERROR: no progress while sending pair %0d", ptr);
                end else begin
                    $display("ERROR: outputs stalled with %0d instructions outstanding",
                             outstanding);
                end
                stop = 1'b1;
            end else if (cyc > CYCLE_LIMIT) begin
                other_errs++;
                $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
                stop = 1'b1;
            end
        end

        for (int t = 0; t < NUM_TAGS; t++) begin
            if (known[t]) begin
                check_count("outputs of one tag", inst_tag_t'(seen[t]), inst_tag_t'(1));
            end
        end
        if (max_low < 3) begin
            other_errs++;
            $display("ERROR: o_in_ready never stayed low while the queue was full");
        end
        $display("errors: value %0d, count %0d, other %0d", value_errs, count_errs, other_errs);
        if (value_errs + count_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- iq_top.sv
`include "iq_consts.svh"

module iq_top
    import iq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic [`IQ_PORTS-1:0] i_in_vld,
    input  exe_info_t [`IQ_PORTS-1:0] i_in_info,
    output logic o_in_ready,
    input  wb_port_t [`IQ_WB_PORTS-1:0] i_wb,
    input  logic i_issue_hold,
    output logic [`IQ_PORTS-1:0] o_spec_wakeup_vld,
    output preg_idx_t [`IQ_PORTS-1:0] o_spec_wakeup_idx,
    output logic [`IQ_PORTS-1:0] o_out_vld,
    output issue_bundle_t [`IQ_PORTS-1:0] o_out_bundle
);

    // dispatch to queue
    logic can_enq;
    logic [`IQ_PORTS-1:0] enq_req;
    exe_info_t [`IQ_PORTS-1:0] enq_info;
    logic [`IQ_PORTS-1:0][`IQ_NUM_SRCS-1:0] enq_src_rdy;

    // dispatch to register read
    logic [(1<<`IQ_PREG_W)-1:0] preg_valid;
    logic [`IQ_PORTS-1:0] dst_busy_vld;
    preg_idx_t [`IQ_PORTS-1:0] dst_busy_idx;

    // queue and register read loop
    logic [`IQ_PORTS-1:0] can_issue;
    iq_idx_t [`IQ_PORTS-1:0] issue_idx;
    exe_info_t [`IQ_PORTS-1:0] issue_info;
    logic [`IQ_PORTS-1:0] finished;
    logic [`IQ_PORTS-1:0] replay;
    iq_idx_t [`IQ_PORTS-1:0] feedback_idx;

    iq_dispatch u_dispatch (
        .clk(clk),
        .rst(rst),
        .i_in_vld(i_in_vld),
        .i_in_info(i_in_info),
        .o_in_ready(o_in_ready),
        .i_can_enq(can_enq),
        .i_preg_valid(preg_valid),
        .i_wb(i_wb),
        .o_enq_req(enq_req),
        .o_enq_info(enq_info),
        .o_enq_src_rdy(enq_src_rdy),
        .o_dst_busy_vld(dst_busy_vld),
        .o_dst_busy_idx(dst_busy_idx)
    );

    issue_queue u_queue (
        .clk(clk),
        .rst(rst),
        .i_enq_req(enq_req),
        .i_enq_info(enq_info),
        .i_enq_src_rdy(enq_src_rdy),
        .o_can_enq(can_enq),
        .i_wb(i_wb),
        .o_can_issue(can_issue),
        .o_issue_idx(issue_idx),
        .o_issue_info(issue_info),
        .i_finished(finished),
        .i_replay(replay),
        .i_feedback_idx(feedback_idx),
        .o_spec_wakeup_vld(o_spec_wakeup_vld),
        .o_spec_wakeup_idx(o_spec_wakeup_idx)
    );

    iq_regread u_regread (
        .clk(clk),
        .rst(rst),
        .i_can_issue(can_issue),
        .i_issue_idx(issue_idx),
        .i_issue_info(issue_info),
        .i_issue_hold(i_issue_hold),
        .i_wb(i_wb),
        .i_dst_busy_vld(dst_busy_vld),
        .i_dst_busy_idx(dst_busy_idx),
        .o_preg_valid(preg_valid),
        .o_finished(finished),
        .o_replay(replay),
        .o_feedback_idx(feedback_idx),
        .o_out_vld(o_out_vld),
        .o_out_bundle(o_out_bundle)
    );

endmodule

//--- issue_queue.sv
`include "iq_consts.svh"

module issue_queue
    import iq_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic [`IQ_PORTS-1:0] i_enq_req,
    input  exe_info_t [`IQ_PORTS-1:0] i_enq_info,
    input  logic [`IQ_PORTS-1:0][`IQ_NUM_SRCS-1:0] i_enq_src_rdy,
    output logic o_can_enq,
    input  wb_port_t [`IQ_WB_PORTS-1:0] i_wb,
    output logic [`IQ_PORTS-1:0] o_can_issue,
    output iq_idx_t [`IQ_PORTS-1:0] o_issue_idx,
    output exe_info_t [`IQ_PORTS-1:0] o_issue_info,
    input  logic [`IQ_PORTS-1:0] i_finished,
    input  logic [`IQ_PORTS-1:0] i_replay,
    input  iq_idx_t [`IQ_PORTS-1:0] i_feedback_idx,
    output logic [`IQ_PORTS-1:0] o_spec_wakeup_vld,
    output preg_idx_t [`IQ_PORTS-1:0] o_spec_wakeup_idx
);

    localparam int DEPTH = `IQ_DEPTH;
    localparam int PORTS = `IQ_PORTS;
    localparam int NSRC = `IQ_NUM_SRCS;
    localparam int NWB = `IQ_WB_PORTS;

    iq_entry_t buffer [DEPTH];

    logic [DEPTH-1:0] entry_vld;
    logic [DEPTH-1:0] entry_ready;

    logic [PORTS-1:0] enq_found;
    iq_idx_t [PORTS-1:0] enq_idx;
    logic [PORTS-1:0] sel_found;
    iq_idx_t [PORTS-1:0] sel_idx;
    logic [PORTS-1:0] real_enq;

    // T0 choice, presented to register read in T1
    logic [PORTS-1:0] saved_found;
    iq_idx_t [PORTS-1:0] saved_idx;

    for (genvar i = 0; i < DEPTH; i++) begin : g_entry
        assign entry_vld[i] = buffer[i].vld;
        // speculative bits already cover the definite ones
        assign entry_ready[i] = buffer[i].vld && !buffer[i].issued &&
                                (&buffer[i].src_spec_rdy);
    end

    // free and ready pick, highest index first, one entry per port
    always_comb begin
        logic [DEPTH-1:0] free_mask;
        logic [DEPTH-1:0] rdy_mask;
        free_mask = ~entry_vld;
        rdy_mask = entry_ready;
        for (int p = 0; p < PORTS; p++) begin
            enq_found[p] = 1'b0;
            enq_idx[p] = '0;
            sel_found[p] = 1'b0;
            sel_idx[p] = '0;
            for (int i = DEPTH - 1; i >= 0; i--) begin
                if (free_mask[i] && !enq_found[p]) begin
                    enq_found[p] = 1'b1;
                    enq_idx[p] = iq_idx_t'(i);
                end
                if (rdy_mask[i] && !sel_found[p]) begin
                    sel_found[p] = 1'b1;
                    sel_idx[p] = iq_idx_t'(i);
                end
            end
            // hide the picks from the next port
            if (enq_found[p]) begin
                free_mask[enq_idx[p]] = 1'b0;
            end
            if (sel_found[p]) begin
                rdy_mask[sel_idx[p]] = 1'b0;
            end
        end
    end

    assign o_can_enq = &enq_found;
    assign real_enq = i_enq_req & {PORTS{o_can_enq}};

    // a selected producer wakes its consumers before its data exists
    for (genvar p = 0; p < PORTS; p++) begin : g_port
        assign o_spec_wakeup_vld[p] = sel_found[p] & buffer[sel_idx[p]].info.dst_wen;
        assign o_spec_wakeup_idx[p] = buffer[sel_idx[p]].info.dst_idx;
        assign o_issue_info[p] = buffer[saved_idx[p]].info;

        a_feedback_valid: assert property (@(posedge clk) disable iff (rst)
            (i_finished[p] | i_replay[p]) |-> buffer[i_feedback_idx[p]].vld);
    end

    assign o_can_issue = saved_found;
    assign o_issue_idx = saved_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            saved_found <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                buffer[i].vld <= 1'b0;
            end
        end else begin
            saved_found <= sel_found;
            saved_idx <= sel_idx;

            for (int p = 0; p < PORTS; p++) begin
                if (real_enq[p]) begin
                    buffer[enq_idx[p]].vld <= 1'b1;
                    buffer[enq_idx[p]].issued <= 1'b0;
                    buffer[enq_idx[p]].src_rdy <= i_enq_src_rdy[p];
                    buffer[enq_idx[p]].src_spec_rdy <= i_enq_src_rdy[p];
                    buffer[enq_idx[p]].info <= i_enq_info[p];
                end
                if (sel_found[p]) begin
                    buffer[sel_idx[p]].issued <= 1'b1;
                end
                if (i_finished[p]) begin
                    buffer[i_feedback_idx[p]].vld <= 1'b0;
                end else if (i_replay[p]) begin
                    // back to what is known for sure
                    buffer[i_feedback_idx[p]].issued <= 1'b0;
                    buffer[i_feedback_idx[p]].src_spec_rdy <= buffer[i_feedback_idx[p]].src_rdy;
                end
            end

            // wakeup comes last so it wins over a replay restore
            for (int i = 0; i < DEPTH; i++) begin
                for (int s = 0; s < NSRC; s++) begin
                    for (int w = 0; w < NWB; w++) begin
                        if (buffer[i].vld && i_wb[w].vld &&
                            i_wb[w].idx == buffer[i].info.src_idx[s]) begin
                            buffer[i].src_rdy[s] <= 1'b1;
                            buffer[i].src_spec_rdy[s] <= 1'b1;
                        end
                    end
                    for (int p = 0; p < PORTS; p++) begin
                        if (buffer[i].vld && o_spec_wakeup_vld[p] &&
                            o_spec_wakeup_idx[p] == buffer[i].info.src_idx[s]) begin
                            buffer[i].src_spec_rdy[s] <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    a_fb_exclusive: assert property (@(posedge clk) disable iff (rst)
        (i_finished & i_replay) == '0);

endmodule
